// ==== cache_pkg.sv ====
package cache_pkg;

    ////////////////////
    // Widths fixed by the CPU
    ////////////////////

    localparam int ADDR_W = 30;            // Word address, byte bits dropped
    localparam int DATA_W = 32;

    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [DATA_W/8-1:0] byte_en_t;    // One enable per byte lane
    typedef logic [ADDR_W-1:0]   addr_t;

    ////////////////////
    // Miss handling
    ////////////////////

    // State of the manage unit, one miss in flight at most
    typedef enum logic [2:0] {
        NORMAL,         // Lookups only
        IC_MISS,        // Refill I-cache
        DC_MISS,        // Refill D-cache
        DC_WB,          // Dirty D-cache victim goes out first
        DOUBLE_MISS     // Refill I-cache, D-cache waits
    } miss_state_e;

    // Request toward the block-wide memory port
    typedef struct packed {
        logic  en;      // Memory needed this cycle
        logic  write;   // Write-back of wb_block
        addr_t addr;    // Block aligned, offset bits zero
    } mem_req_t;

endpackage

// ==== cache_2ways.sv ====
`timescale 1ns/1ps

module cache_2ways import cache_pkg::*; #(
    parameter int OFFSET_WIDTH = 3,
    parameter int INDEX_WIDTH  = 6,
    parameter int TAG_WIDTH    = ADDR_W - OFFSET_WIDTH - INDEX_WIDTH,
    localparam int SETS        = 1 << INDEX_WIDTH,
    localparam int BLOCK_W     = DATA_W << OFFSET_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    enable,       // Real CPU access this cycle
    input  logic                    write,
    input  logic                    fill,         // Replace victim with fill_block
    input  byte_en_t                byte_en,
    input  logic [TAG_WIDTH-1:0]    tag,
    input  logic [INDEX_WIDTH-1:0]  index,
    input  logic [OFFSET_WIDTH-1:0] word_sel,
    input  word_t                   wdata,
    input  logic [BLOCK_W-1:0]      fill_block,
    output logic                    hit,
    output logic                    dirty,        // Dirty bit of the victim
    output logic                    victim_valid,
    output logic [TAG_WIDTH-1:0]    victim_tag,
    output word_t                   rdata,
    output logic [BLOCK_W-1:0]      wb_block
);

    ////////////////////
    // Storage
    ////////////////////

    logic [TAG_WIDTH-1:0] tag_q  [2][SETS];
    logic [BLOCK_W-1:0]   data_q [2][SETS];
    logic [1:0][SETS-1:0] valid_q;
    logic [1:0][SETS-1:0] dirty_q;
    logic [SETS-1:0]      lru_q;        // Least recently used way per set

    logic [1:0] way_hit;
    logic       hit_way;
    logic       victim_way;
    logic       do_write;

    ////////////////////
    // Lookup
    ////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][index] && (tag_q[w][index] == tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // Empty way first, else the LRU one
    always_comb begin
        if (!valid_q[0][index]) begin
            victim_way = 1'b0;
        end else if (!valid_q[1][index]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lru_q[index];
        end
    end

    assign rdata        = data_q[hit_way][index][word_sel*DATA_W +: DATA_W];
    assign dirty        = dirty_q[victim_way][index];
    assign victim_valid = valid_q[victim_way][index];
    assign victim_tag   = tag_q[victim_way][index];
    assign wb_block     = data_q[victim_way][index];

    assign do_write = enable & write & hit;

    ////////////////////
    // Update
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else if (fill) begin
            valid_q[victim_way][index] <= 1'b1;
            dirty_q[victim_way][index] <= 1'b0;     // Refilled line is clean
            lru_q[index]               <= ~victim_way;  // and becomes MRU
        end else if (enable && hit) begin
            lru_q[index] <= ~hit_way;
            if (do_write) begin
                dirty_q[hit_way][index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[victim_way][index]  <= tag;
            data_q[victim_way][index] <= fill_block;
        end else if (do_write) begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (byte_en[b]) begin
                    data_q[hit_way][index][word_sel*DATA_W + b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // Fill only follows a miss, so a tag never sits in both ways
    assert property (@(posedge clk) disable iff (rst)
        fill |=> !(way_hit[0] && way_hit[1]));

endmodule

// ==== cache_control.sv ====
`timescale 1ns/1ps

module cache_control import cache_pkg::*; #(
    parameter int OFFSET_WIDTH = 3,
    parameter int INDEX_WIDTH  = 6,
    parameter int TAG_WIDTH    = ADDR_W - OFFSET_WIDTH - INDEX_WIDTH
) (
    input  miss_state_e             state,
    input  logic                    dc_read,
    input  logic                    dc_write,
    input  byte_en_t                dc_byte_en,
    input  logic                    ic_hit,
    input  logic                    dc_hit,
    input  logic                    dc_dirty,
    input  logic                    dc_victim_valid,
    input  logic [OFFSET_WIDTH-1:0] ic_offset,
    input  logic [OFFSET_WIDTH-1:0] dc_offset,
    input  logic [TAG_WIDTH-1:0]    ic_tag,
    input  logic [TAG_WIDTH-1:0]    dc_tag,
    input  logic [TAG_WIDTH-1:0]    dc_victim_tag,
    input  logic [INDEX_WIDTH-1:0]  ic_index,
    input  logic [INDEX_WIDTH-1:0]  dc_index,
    // I-cache commands
    output logic                    ic_cmd_enable,
    output logic                    ic_cmd_fill,
    output logic [OFFSET_WIDTH-1:0] ic_cmd_word_sel,
    // D-cache commands
    output logic                    dc_cmd_enable,
    output logic                    dc_cmd_write,
    output logic                    dc_cmd_fill,
    output byte_en_t                dc_cmd_byte_en,
    output logic [OFFSET_WIDTH-1:0] dc_cmd_word_sel,
    output mem_req_t                mem_req,
    output miss_state_e             next_state
);

    logic  dc_access;
    logic  ic_miss;
    logic  dc_miss;
    logic  dc_wb_need;
    addr_t ic_block_addr;
    addr_t dc_block_addr;
    addr_t wb_block_addr;

    assign dc_access  = dc_read | dc_write;
    assign ic_miss    = ~ic_hit;                // Fetch side looks up every cycle
    assign dc_miss    = dc_access & ~dc_hit;
    assign dc_wb_need = dc_victim_valid & dc_dirty;

    assign ic_block_addr = {ic_tag, ic_index, {OFFSET_WIDTH{1'b0}}};
    assign dc_block_addr = {dc_tag, dc_index, {OFFSET_WIDTH{1'b0}}};
    assign wb_block_addr = {dc_victim_tag, dc_index, {OFFSET_WIDTH{1'b0}}};

    assign ic_cmd_word_sel = ic_offset;
    assign dc_cmd_word_sel = dc_offset;

    always_comb begin
        ic_cmd_enable  = 1'b0;
        ic_cmd_fill    = 1'b0;
        dc_cmd_enable  = 1'b0;
        dc_cmd_write   = 1'b0;
        dc_cmd_fill    = 1'b0;
        dc_cmd_byte_en = '0;
        mem_req        = '0;
        next_state     = NORMAL;

        case (state)
            NORMAL: begin
                ic_cmd_enable = 1'b1;
                dc_cmd_enable = dc_access;
                // I-side goes first on a double miss
                if (ic_miss && dc_miss) begin
                    next_state = DOUBLE_MISS;
                end else if (ic_miss) begin
                    next_state = IC_MISS;
                end else if (dc_miss) begin
                    next_state = dc_wb_need ? DC_WB : DC_MISS;
                end
                // Store lands only when nothing else holds the CPU
                if (!ic_miss && dc_write && dc_hit) begin
                    dc_cmd_write   = 1'b1;
                    dc_cmd_byte_en = dc_byte_en;
                end
            end
            IC_MISS: begin
                mem_req     = '{en: 1'b1, write: 1'b0, addr: ic_block_addr};
                ic_cmd_fill = 1'b1;
            end
            DOUBLE_MISS: begin
                mem_req     = '{en: 1'b1, write: 1'b0, addr: ic_block_addr};
                ic_cmd_fill = 1'b1;
                next_state  = dc_wb_need ? DC_WB : DC_MISS;   // D-side after refill
            end
            DC_WB: begin
                mem_req    = '{en: 1'b1, write: 1'b1, addr: wb_block_addr};
                next_state = DC_MISS;
            end
            DC_MISS: begin
                mem_req     = '{en: 1'b1, write: 1'b0, addr: dc_block_addr};
                dc_cmd_fill = 1'b1;
            end
            default: next_state = NORMAL;
        endcase
    end

endmodule

// ==== cache_manage_unit.sv ====
`timescale 1ns/1ps

module cache_manage_unit import cache_pkg::*; #(
    parameter int OFFSET_WIDTH = 3,
    parameter int INDEX_WIDTH  = 6,
    localparam int TAG_WIDTH   = ADDR_W - OFFSET_WIDTH - INDEX_WIDTH,
    localparam int BLOCK_W     = DATA_W << OFFSET_WIDTH
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               dc_read,
    input  logic               dc_write,
    input  byte_en_t           dc_byte_en,
    input  addr_t              ic_addr,
    input  addr_t              dc_addr,
    input  word_t              dc_wdata,
    input  logic               mem_ready,     // One pulse per transaction
    input  logic [BLOCK_W-1:0] fill_block,
    output word_t              ic_rdata,
    output word_t              dc_rdata,
    output logic               mem_stall,
    output mem_req_t           mem_req,
    output logic [BLOCK_W-1:0] wb_block
);

    miss_state_e state;
    miss_state_e next_state;
    logic        write_after_load;     // Stalled access was a store

    logic [TAG_WIDTH-1:0]    ic_tag;
    logic [TAG_WIDTH-1:0]    dc_tag;
    logic [TAG_WIDTH-1:0]    dc_victim_tag;
    logic [INDEX_WIDTH-1:0]  ic_index;
    logic [INDEX_WIDTH-1:0]  dc_index;
    logic [OFFSET_WIDTH-1:0] ic_offset;
    logic [OFFSET_WIDTH-1:0] dc_offset;

    logic ic_hit;
    logic dc_hit;
    logic dc_dirty;
    logic dc_victim_valid;

    logic                    ic_cmd_enable;
    logic                    ic_cmd_fill;
    logic [OFFSET_WIDTH-1:0] ic_cmd_word_sel;
    logic                    dc_cmd_enable;
    logic                    dc_cmd_write;
    logic                    dc_cmd_fill;
    byte_en_t                dc_cmd_byte_en;
    logic [OFFSET_WIDTH-1:0] dc_cmd_word_sel;

    ////////////////////
    // Address split
    ////////////////////

    assign ic_tag    = ic_addr[ADDR_W-1 -: TAG_WIDTH];
    assign ic_index  = ic_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign ic_offset = ic_addr[OFFSET_WIDTH-1:0];
    assign dc_tag    = dc_addr[ADDR_W-1 -: TAG_WIDTH];
    assign dc_index  = dc_addr[OFFSET_WIDTH +: INDEX_WIDTH];
    assign dc_offset = dc_addr[OFFSET_WIDTH-1:0];

    cache_control #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH),
        .TAG_WIDTH    (TAG_WIDTH)
    ) i_control (
        .state           (state),
        .dc_read         (dc_read),
        .dc_write        (dc_write),
        .dc_byte_en      (dc_byte_en),
        .ic_hit          (ic_hit),
        .dc_hit          (dc_hit),
        .dc_dirty        (dc_dirty),
        .dc_victim_valid (dc_victim_valid),
        .ic_offset       (ic_offset),
        .dc_offset       (dc_offset),
        .ic_tag          (ic_tag),
        .dc_tag          (dc_tag),
        .dc_victim_tag   (dc_victim_tag),
        .ic_index        (ic_index),
        .dc_index        (dc_index),
        .ic_cmd_enable   (ic_cmd_enable),
        .ic_cmd_fill     (ic_cmd_fill),
        .ic_cmd_word_sel (ic_cmd_word_sel),
        .dc_cmd_enable   (dc_cmd_enable),
        .dc_cmd_write    (dc_cmd_write),
        .dc_cmd_fill     (dc_cmd_fill),
        .dc_cmd_byte_en  (dc_cmd_byte_en),
        .dc_cmd_word_sel (dc_cmd_word_sel),
        .mem_req         (mem_req),
        .next_state      (next_state)
    );

    // Read only, never dirty
    cache_2ways #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH),
        .TAG_WIDTH    (TAG_WIDTH)
    ) i_icache (
        .clk          (clk),
        .rst          (rst),
        .enable       (ic_cmd_enable),
        .write        (1'b0),
        .fill         (ic_cmd_fill & mem_ready),   // Block arrives with the pulse
        .byte_en      ('0),
        .tag          (ic_tag),
        .index        (ic_index),
        .word_sel     (ic_cmd_word_sel),
        .wdata        ('0),
        .fill_block   (fill_block),
        .hit          (ic_hit),
        .dirty        (),
        .victim_valid (),
        .victim_tag   (),
        .rdata        (ic_rdata),
        .wb_block     ()
    );

    cache_2ways #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH),
        .TAG_WIDTH    (TAG_WIDTH)
    ) i_dcache (
        .clk          (clk),
        .rst          (rst),
        .enable       (dc_cmd_enable),
        .write        (dc_cmd_write),
        .fill         (dc_cmd_fill & mem_ready),
        .byte_en      (dc_cmd_byte_en),
        .tag          (dc_tag),
        .index        (dc_index),
        .word_sel     (dc_cmd_word_sel),
        .wdata        (dc_wdata),
        .fill_block   (fill_block),
        .hit          (dc_hit),
        .dirty        (dc_dirty),
        .victim_valid (dc_victim_valid),
        .victim_tag   (dc_victim_tag),
        .rdata        (dc_rdata),
        .wb_block     (wb_block)
    );

    ////////////////////
    // Miss state
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= NORMAL;
            write_after_load <= 1'b0;
        end else if (state == NORMAL) begin
            state            <= next_state;
            write_after_load <= 1'b0;
        end else begin
            if (dc_write) begin
                write_after_load <= 1'b1;
            end
            if (mem_ready) begin
                state <= next_state;    // Held until memory answers
            end
        end
    end

    assign mem_stall = (state != NORMAL) || (next_state != NORMAL) || write_after_load;

    // Memory sees one request per transaction
    assert property (@(posedge clk) disable iff (rst)
        mem_req.en && !mem_ready |=> $stable(mem_req));

    // Stall already up in the cycle the miss was seen
    assert property (@(posedge clk) disable iff (rst)
        state != NORMAL |-> $past(mem_stall));

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker import cache_pkg::*; #(
    parameter int OFFSET_WIDTH = 3,
    parameter int EXPECTED_WB  = 0,
    localparam int WORDS       = 1 << OFFSET_WIDTH,
    localparam int BLOCK_W     = DATA_W << OFFSET_WIDTH
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               dc_read,
    input  logic               dc_write,
    input  byte_en_t           dc_byte_en,
    input  addr_t              ic_addr,
    input  addr_t              dc_addr,
    input  word_t              dc_wdata,
    input  word_t              ic_rdata,
    input  word_t              dc_rdata,
    input  logic               mem_stall,
    input  mem_req_t           mem_req,
    input  logic               mem_ready,
    input  logic [BLOCK_W-1:0] wb_block,
    input  logic               entry_start,    // First cycle of a table entry
    input  logic               expect_hit,
    input  logic               done,
    output int                 data_errors,
    output int                 flow_errors,
    output int                 wb_count
);

    word_t shadow [addr_t];     // Words written by the CPU

    // Same pattern as the memory model
    function automatic word_t init_word(addr_t a);
        return {a, 2'b01} ^ 32'h9E37_79B9;
    endfunction

    function automatic word_t expected_word(addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return init_word(a);
    endfunction

    function automatic void store_word(addr_t a, byte_en_t be, word_t d);
        word_t w;
        w = expected_word(a);
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            if (be[b]) begin
                w[b*8 +: 8] = d[b*8 +: 8];
            end
        end
        shadow[a] = w;
    endfunction

    ////////////////////
    // Per-edge checks
    ////////////////////

    always @(posedge clk) begin : check
        word_t exp_w;
        addr_t wa;
        if (rst) begin
            data_errors = 0;
            flow_errors = 0;
            wb_count    = 0;
        end else begin
            if (entry_start && (mem_stall !== !expect_hit)) begin
                flow_errors++;
                $display("Error at %0t: mem_stall %b in first cycle of entry, expected %b",
                         $time, mem_stall, !expect_hit);
            end
            // CPU side only counts on unstalled edges
            if (!mem_stall) begin
                exp_w = expected_word(ic_addr);
                if (ic_rdata !== exp_w) begin
                    data_errors++;
                    $display("Error at %0t: I read %h gave %h, expected %h",
                             $time, ic_addr, ic_rdata, exp_w);
                end
                if (dc_read) begin
                    exp_w = expected_word(dc_addr);
                    if (dc_rdata !== exp_w) begin
                        data_errors++;
                        $display("Error at %0t: D read %h gave %h, expected %h",
                                 $time, dc_addr, dc_rdata, exp_w);
                    end
                end
                if (dc_write) begin
                    store_word(dc_addr, dc_byte_en, dc_wdata);
                end
            end
            if (mem_req.en && mem_req.write && mem_ready) begin
                wb_count++;
                for (int w = 0; w < WORDS; w++) begin
                    wa    = mem_req.addr + addr_t'(w);
                    exp_w = expected_word(wa);
                    if (wb_block[w*DATA_W +: DATA_W] !== exp_w) begin
                        data_errors++;
                        $display("Error at %0t: write-back word %h is %h, expected %h",
                                 $time, wa, wb_block[w*DATA_W +: DATA_W], exp_w);
                    end
                end
            end
            if (done && (wb_count != EXPECTED_WB)) begin
                flow_errors++;
                $display("The run made %0d write-backs where the table calls for %0d",
                         wb_count, EXPECTED_WB);
            end
        end
    end

endmodule

// ==== tb_cache.sv ====
`timescale 1ns/1ps

module tb_cache
    import cache_pkg::*;
();

    localparam int OFFSET_WIDTH = 3;
    localparam int INDEX_WIDTH  = 6;
    localparam int WORDS        = 1 << OFFSET_WIDTH;
    localparam int BLOCK_W      = DATA_W << OFFSET_WIDTH;
    localparam int TABLE_LEN    = 16;
    localparam int RESET_CYCLES = 10;
    localparam int EXPECTED_WB  = 1;    // Only entry 7 evicts a dirty line

    typedef enum logic [1:0] {OP_IREAD, OP_DREAD, OP_DWRITE, OP_BOTH} op_e;

    typedef struct packed {
        op_e      op;
        addr_t    ic_addr;
        addr_t    dc_addr;
        byte_en_t be;
        word_t    wdata;
        logic     hit;      // No stall expected in the first cycle
    } stim_t;

    logic               clk;
    logic               rst;
    logic               dc_read;
    logic               dc_write;
    byte_en_t           dc_byte_en;
    addr_t              ic_addr;
    addr_t              dc_addr;
    word_t              dc_wdata;
    logic               mem_ready;
    logic [BLOCK_W-1:0] fill_block;
    word_t              ic_rdata;
    word_t              dc_rdata;
    logic               mem_stall;
    mem_req_t           mem_req;
    logic [BLOCK_W-1:0] wb_block;
    logic               entry_start;
    logic               expect_hit;
    logic               done;
    int                 data_errors;
    int                 flow_errors;
    int                 wb_count;

    stim_t              stim [TABLE_LEN];
    logic [BLOCK_W-1:0] mem_blocks [addr_t];    // Blocks written back so far

    cache_manage_unit #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .INDEX_WIDTH  (INDEX_WIDTH)
    ) i_dut (.*);

    tb_checker #(
        .OFFSET_WIDTH (OFFSET_WIDTH),
        .EXPECTED_WB  (EXPECTED_WB)
    ) i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // Memory model
    ////////////////////

    function automatic word_t init_word(addr_t a);
        return {a, 2'b01} ^ 32'h9E37_79B9;     // Distinct for every word address
    endfunction

    function automatic logic [BLOCK_W-1:0] read_block(addr_t base);
        logic [BLOCK_W-1:0] blk;
        if (mem_blocks.exists(base)) begin
            return mem_blocks[base];
        end
        for (int w = 0; w < WORDS; w++) begin
            blk[w*DATA_W +: DATA_W] = init_word(base + addr_t'(w));
        end
        return blk;
    endfunction

    initial begin
        int       delay;
        mem_req_t req;
        mem_ready  = 1'b0;
        fill_block = '0;
        void'($urandom(93));
        forever begin
            @(posedge clk);
            if (!rst && mem_req.en) begin
                delay = 1 + int'($urandom % 4);     // 1 to 4 cycles
                repeat (delay - 1) @(posedge clk);
                req = mem_req;
                if (req.write) begin
                    mem_blocks[req.addr] = wb_block;
                end else begin
                    fill_block <= read_block(req.addr);
                end
                mem_ready <= 1'b1;
                @(posedge clk);
                mem_ready <= 1'b0;
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic load_table();
        // Set 5 of the D-cache takes tags from 0x028, 0x228 and 0x428
        stim[0]  = '{OP_IREAD,  30'h3000, 30'h0000, 4'b0000, 32'h0000_0000, 1'b0};
        stim[1]  = '{OP_IREAD,  30'h3003, 30'h0000, 4'b0000, 32'h0000_0000, 1'b1};
        stim[2]  = '{OP_DREAD,  30'h3003, 30'h0028, 4'b0000, 32'h0000_0000, 1'b0};
        stim[3]  = '{OP_DREAD,  30'h3003, 30'h002B, 4'b0000, 32'h0000_0000, 1'b1};
        stim[4]  = '{OP_DWRITE, 30'h3003, 30'h002A, 4'b0101, 32'h1122_3344, 1'b1};
        stim[5]  = '{OP_DREAD,  30'h3003, 30'h002A, 4'b0000, 32'h0000_0000, 1'b1};
        stim[6]  = '{OP_DREAD,  30'h3003, 30'h0228, 4'b0000, 32'h0000_0000, 1'b0};
        stim[7]  = '{OP_DREAD,  30'h3003, 30'h0428, 4'b0000, 32'h0000_0000, 1'b0};
        stim[8]  = '{OP_DREAD,  30'h3003, 30'h002A, 4'b0000, 32'h0000_0000, 1'b0};
        stim[9]  = '{OP_BOTH,   30'h3100, 30'h1040, 4'b0000, 32'h0000_0000, 1'b0};
        stim[10] = '{OP_DREAD,  30'h3100, 30'h1045, 4'b0000, 32'h0000_0000, 1'b1};
        stim[11] = '{OP_DWRITE, 30'h3100, 30'h2050, 4'b1100, 32'hAABB_CCDD, 1'b0};
        stim[12] = '{OP_DREAD,  30'h3100, 30'h2050, 4'b0000, 32'h0000_0000, 1'b1};
        stim[13] = '{OP_DWRITE, 30'h3100, 30'h2057, 4'b1111, 32'hCAFE_F00D, 1'b1};
        stim[14] = '{OP_DREAD,  30'h3100, 30'h2057, 4'b0000, 32'h0000_0000, 1'b1};
        stim[15] = '{OP_IREAD,  30'h3105, 30'h0000, 4'b0000, 32'h0000_0000, 1'b1};
    endtask

    // Held until an edge with mem_stall low
    task automatic apply_entry(stim_t s);
        ic_addr     <= s.ic_addr;
        dc_addr     <= s.dc_addr;
        dc_read     <= (s.op == OP_DREAD) || (s.op == OP_BOTH);
        dc_write    <= (s.op == OP_DWRITE);
        dc_byte_en  <= s.be;
        dc_wdata    <= s.wdata;
        entry_start <= 1'b1;
        expect_hit  <= s.hit;
        @(posedge clk);
        entry_start <= 1'b0;
        while (mem_stall) begin
            @(posedge clk);
        end
    endtask

    initial begin
        rst         = 1'b1;
        dc_read     = 1'b0;
        dc_write    = 1'b0;
        dc_byte_en  = '0;
        ic_addr     = 30'h3000;
        dc_addr     = '0;
        dc_wdata    = '0;
        entry_start = 1'b0;
        expect_hit  = 1'b0;
        done        = 1'b0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < TABLE_LEN; i++) begin
            apply_entry(stim[i]);
        end
        dc_read  <= 1'b0;
        dc_write <= 1'b0;
        done     <= 1'b1;
        @(posedge clk);
        done <= 1'b0;
        @(negedge clk);     // Checker counts are settled here
        $display("Summary: %0d data errors, %0d flow errors, %0d write-backs",
                 data_errors, flow_errors, wb_count);
        if (data_errors == 0 && flow_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (RESET_CYCLES + TABLE_LEN * 40) @(posedge clk);
        $display("Timeout: the table did not finish within %0d cycles", TABLE_LEN * 40);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== all.f ====
cache_pkg.sv
cache_2ways.sv
cache_control.sv
cache_manage_unit.sv
tb_checker.sv
tb_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cache
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG) && echo "Result: pass" || (echo "Result: fail"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
